//--- logic/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath word width.
`define LEN_WORD 32

// register index width and number of architectural registers.
`define LEN_REG_ADDR 5
`define REG_COUNT 32

// data memory address width; the stack pointer starts at the top of it.
`define LEN_MEMDATA_ADDR 16

// heap grows up from here.
`define HEAP_POINTER_INIT 32'h0000_8000

`endif

//--- logic/core_pkg.sv
`include "core_config.svh"

package core_pkg;

    typedef logic [`LEN_WORD-1:0] word_t;
    typedef logic [`LEN_REG_ADDR-1:0] reg_addr_t;
    typedef logic [31:0] inst_t;  // instruction words are always 32 bits.
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    localparam opcode_t opc_op = 7'b0110011;
    localparam opcode_t opc_op_imm = 7'b0010011;
    localparam opcode_t opc_lui = 7'b0110111;

    localparam funct7_t f7_base = 7'b0000000;
    localparam funct7_t f7_alt = 7'b0100000;  // selects sub and sra.

    localparam funct3_t f3_add = 3'b000;
    localparam funct3_t f3_sll = 3'b001;
    localparam funct3_t f3_slt = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor = 3'b100;
    localparam funct3_t f3_srl = 3'b101;
    localparam funct3_t f3_or = 3'b110;
    localparam funct3_t f3_and = 3'b111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b  // lui passes the immediate straight through.
    } alu_op_t;

endpackage

//--- logic/issue_if.sv
`timescale 1ns/100ps

interface issue_if;

    logic valid;
    core_pkg::alu_op_t op;
    core_pkg::reg_addr_t rd;
    core_pkg::word_t opa;
    core_pkg::word_t opb;

    modport issue (
        output valid,
        output op,
        output rd,
        output opa,
        output opb
    );

    modport exec (
        input valid,
        input op,
        input rd,
        input opa,
        input opb
    );

endinterface

//--- logic/reg_file.sv
`timescale 1ns/100ps

`include "core_config.svh"

module reg_file (
    input  logic                clk,
    input  logic                rstn,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    input  logic                wr_en,
    input  core_pkg::reg_addr_t wr_addr,
    input  core_pkg::word_t     wr_data
);

    localparam core_pkg::word_t ra_init = '0;
    localparam core_pkg::word_t sp_init = core_pkg::word_t'(1) << `LEN_MEMDATA_ADDR;
    localparam core_pkg::word_t gp_init = `HEAP_POINTER_INIT;

    core_pkg::word_t regs [`REG_COUNT];

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];  // x0 is never stored.
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            regs[1] <= ra_init;
            regs[2] <= sp_init;  // stack starts at the top of data memory.
            regs[3] <= gp_init;
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // an enabled write must carry a known address and known data.
    write_port_known: assert property (
        @(posedge clk) disable iff (!rstn)
        wr_en |-> !$isunknown({wr_addr, wr_data})
    ) else $error("register file write with an unknown address or data.");

endmodule

//--- logic/inst_decode.sv
`timescale 1ns/100ps

module inst_decode (
    input  core_pkg::inst_t     inst,
    output core_pkg::alu_op_t   op,
    output core_pkg::reg_addr_t rd,
    output core_pkg::reg_addr_t rs1,
    output core_pkg::reg_addr_t rs2,
    output core_pkg::word_t     imm,
    output logic                use_imm,
    output logic                uses_rs1,
    output logic                illegal
);

    core_pkg::opcode_t opcode;
    core_pkg::funct3_t funct3;
    core_pkg::funct7_t funct7;
    core_pkg::word_t imm_i;
    core_pkg::word_t imm_sh;
    core_pkg::word_t imm_u;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rd = inst[11:7];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_sh = {27'b0, inst[24:20]};  // shift amount only.
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        op = core_pkg::alu_add;
        imm = imm_i;
        use_imm = 1'b0;
        uses_rs1 = 1'b1;
        illegal = 1'b0;
        case (opcode)
            core_pkg::opc_op: begin
                if (funct7 == core_pkg::f7_base) begin
                    case (funct3)
                        core_pkg::f3_add: op = core_pkg::alu_add;
                        core_pkg::f3_sll: op = core_pkg::alu_sll;
                        core_pkg::f3_slt: op = core_pkg::alu_slt;
                        core_pkg::f3_sltu: op = core_pkg::alu_sltu;
                        core_pkg::f3_xor: op = core_pkg::alu_xor;
                        core_pkg::f3_srl: op = core_pkg::alu_srl;
                        core_pkg::f3_or: op = core_pkg::alu_or;
                        default: op = core_pkg::alu_and;
                    endcase
                end else if ((funct7 == core_pkg::f7_alt) && (funct3 == core_pkg::f3_add)) begin
                    op = core_pkg::alu_sub;
                end else if ((funct7 == core_pkg::f7_alt) && (funct3 == core_pkg::f3_srl)) begin
                    op = core_pkg::alu_sra;
                end else begin
                    illegal = 1'b1;
                end
            end
            core_pkg::opc_op_imm: begin
                use_imm = 1'b1;
                case (funct3)
                    core_pkg::f3_add: op = core_pkg::alu_add;
                    core_pkg::f3_slt: op = core_pkg::alu_slt;
                    core_pkg::f3_sltu: op = core_pkg::alu_sltu;
                    core_pkg::f3_xor: op = core_pkg::alu_xor;
                    core_pkg::f3_or: op = core_pkg::alu_or;
                    core_pkg::f3_and: op = core_pkg::alu_and;
                    core_pkg::f3_sll: begin
                        op = core_pkg::alu_sll;
                        imm = imm_sh;
                        illegal = (funct7 != core_pkg::f7_base);
                    end
                    default: begin
                        imm = imm_sh;  // srli and srai differ only in funct7.
                        if (funct7 == core_pkg::f7_base) begin
                            op = core_pkg::alu_srl;
                        end else if (funct7 == core_pkg::f7_alt) begin
                            op = core_pkg::alu_sra;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                endcase
            end
            core_pkg::opc_lui: begin
                op = core_pkg::alu_pass_b;
                imm = imm_u;
                use_imm = 1'b1;
                uses_rs1 = 1'b0;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

//--- logic/issue_stage.sv
`timescale 1ns/100ps

module issue_stage (
    input  logic                clk,
    input  logic                rstn,
    input  logic                in_valid,
    input  core_pkg::inst_t     in_inst,
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    input  core_pkg::word_t     fwd_data,
    issue_if.issue              iss,
    output logic                illegal
);

    core_pkg::alu_op_t dec_op;
    core_pkg::reg_addr_t dec_rd;
    core_pkg::reg_addr_t dec_rs1;
    core_pkg::reg_addr_t dec_rs2;
    core_pkg::word_t dec_imm;
    logic dec_use_imm;
    logic dec_uses_rs1;
    logic dec_illegal;

    logic fwd1;
    logic fwd2;
    core_pkg::word_t src1;
    core_pkg::word_t src2;
    logic issue_en;
    logic illegal_pend;

    inst_decode inst_decode_i (
        .inst     (in_inst),
        .op       (dec_op),
        .rd       (dec_rd),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .imm      (dec_imm),
        .use_imm  (dec_use_imm),
        .uses_rs1 (dec_uses_rs1),
        .illegal  (dec_illegal)
    );

    assign rs1_addr = dec_rs1;
    assign rs2_addr = dec_rs2;

    // the instruction ahead has not reached the register file yet.
    assign fwd1 = iss.valid && (iss.rd == dec_rs1) && (dec_rs1 != '0);
    assign fwd2 = iss.valid && (iss.rd == dec_rs2) && (dec_rs2 != '0);

    assign src1 = fwd1 ? fwd_data : rs1_data;
    assign src2 = fwd2 ? fwd_data : rs2_data;

    assign issue_en = in_valid && !dec_illegal;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            iss.valid <= 1'b0;
            illegal_pend <= 1'b0;
            illegal <= 1'b0;
        end else begin
            iss.valid <= issue_en;
            illegal_pend <= in_valid && dec_illegal;
            illegal <= illegal_pend;  // delayed to match the writeback latency.
        end
    end

    always_ff @(posedge clk) begin
        if (issue_en) begin
            iss.op <= dec_op;
            iss.rd <= dec_rd;
            iss.opa <= dec_uses_rs1 ? src1 : '0;
            iss.opb <= dec_use_imm ? dec_imm : src2;
        end
    end

endmodule

//--- logic/alu_stage.sv
`timescale 1ns/100ps

module alu_stage (
    input  logic                clk,
    input  logic                rstn,
    issue_if.exec               ex,
    output core_pkg::word_t     fwd_data,
    output logic                wr_en,
    output core_pkg::reg_addr_t wr_addr,
    output core_pkg::word_t     wr_data,
    output logic                wb_valid,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::word_t     wb_data
);

    core_pkg::word_t result;
    logic [4:0] shamt;

    assign shamt = ex.opb[4:0];  // only the low five bits count for shifts.

    always_comb begin
        result = '0;
        case (ex.op)
            core_pkg::alu_add: result = ex.opa + ex.opb;
            core_pkg::alu_sub: result = ex.opa - ex.opb;
            core_pkg::alu_sll: result = ex.opa << shamt;
            core_pkg::alu_slt: result[0] = $signed(ex.opa) < $signed(ex.opb);
            core_pkg::alu_sltu: result[0] = ex.opa < ex.opb;
            core_pkg::alu_xor: result = ex.opa ^ ex.opb;
            core_pkg::alu_srl: result = ex.opa >> shamt;
            core_pkg::alu_sra: result = core_pkg::word_t'($signed(ex.opa) >>> shamt);
            core_pkg::alu_or: result = ex.opa | ex.opb;
            core_pkg::alu_and: result = ex.opa & ex.opb;
            default: result = ex.opb;
        endcase
    end

    assign fwd_data = result;

    // the write lands on the same edge as the writeback registers.
    assign wr_en = ex.valid;
    assign wr_addr = ex.rd;
    assign wr_data = result;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex.valid) begin
            wb_rd <= ex.rd;
            wb_data <= result;
        end
    end

    // an issued instruction must arrive with a known operation and known operands.
    issue_known: assert property (
        @(posedge clk) disable iff (!rstn)
        ex.valid |-> !$isunknown({ex.op, ex.rd, ex.opa, ex.opb})
    ) else $error("issued instruction with an unknown field.");

endmodule

//--- logic/exec_core.sv
`timescale 1ns/100ps

module exec_core (
    input  logic                clk,
    input  logic                rstn,
    input  logic                in_valid,
    input  core_pkg::inst_t     in_inst,
    output logic                wb_valid,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::word_t     wb_data,
    output logic                illegal
);

    core_pkg::reg_addr_t rs1_addr;
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::word_t rs1_data;
    core_pkg::word_t rs2_data;
    core_pkg::word_t fwd_data;
    logic wr_en;
    core_pkg::reg_addr_t wr_addr;
    core_pkg::word_t wr_data;

    issue_if iss_bus ();

    reg_file reg_file_i (
        .clk      (clk),
        .rstn     (rstn),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    issue_stage issue_stage_i (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .in_inst  (in_inst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .fwd_data (fwd_data),
        .iss      (iss_bus.issue),
        .illegal  (illegal)
    );

    alu_stage alu_stage_i (
        .clk      (clk),
        .rstn     (rstn),
        .ex       (iss_bus.exec),
        .fwd_data (fwd_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

//--- sim/exec_core_tb.sv
`timescale 1ns/100ps

`include "core_config.svh"

module exec_core_tb;

    logic clk;
    logic rstn;
    logic in_valid;
    logic [31:0] in_inst;
    logic wb_valid;
    logic [4:0] wb_rd;
    logic [31:0] wb_data;
    logic illegal;

    integer seed = 32'hb73e;
    logic [31:0] model_regs [32];
    string name_q [$];
    logic ill_q [$];
    logic [4:0] rd_q [$];
    logic [31:0] data_q [$];
    logic [1:0] strobe_hist;
    logic pulse;
    string cur_name;
    logic [31:0] r;
    logic [31:0] c;
    logic [2:0] f3;
    logic [11:0] imm;
    int wait_count;

    exec_core exec_core_i (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .in_inst  (in_inst),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .illegal  (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Verification failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR: %s expected %h actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    function automatic logic [31:0] make_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] fn3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, fn3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] make_i(input logic [11:0] im, input logic [4:0] rs1,
                                           input logic [2:0] fn3, input logic [4:0] rd);
        return {im, rs1, fn3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] make_u(input logic [19:0] im, input logic [4:0] rd);
        return {im, rd, 7'b0110111};
    endfunction

    // models the architectural RV32I semantics in program order.
    function automatic logic model_exec(input logic [31:0] inst, output logic [4:0] rd,
                                        output logic [31:0] data);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] im;
        logic [6:0] f7;
        logic legal;
        rd = inst[11:7];
        f7 = inst[31:25];
        a = model_regs[inst[19:15]];
        b = model_regs[inst[24:20]];
        im = {{20{inst[31]}}, inst[31:20]};
        legal = 1'b1;
        data = '0;
        if (inst[6:0] == 7'b0110111) begin
            data = {inst[31:12], 12'h000};
        end else if (inst[6:0] == 7'b0010011) begin
            case (inst[14:12])
                3'b000: data = a + im;
                3'b010: data = {31'b0, $signed(a) < $signed(im)};
                3'b011: data = {31'b0, a < im};
                3'b100: data = a ^ im;
                3'b110: data = a | im;
                3'b111: data = a & im;
                3'b001: begin
                    if (f7 == 7'h00) data = a << inst[24:20];
                    else legal = 1'b0;
                end
                default: begin
                    if (f7 == 7'h00) data = a >> inst[24:20];
                    else if (f7 == 7'h20) data = $signed(a) >>> inst[24:20];
                    else legal = 1'b0;
                end
            endcase
        end else if (inst[6:0] == 7'b0110011) begin
            if (f7 == 7'h00) begin
                case (inst[14:12])
                    3'b000: data = a + b;
                    3'b001: data = a << b[4:0];
                    3'b010: data = {31'b0, $signed(a) < $signed(b)};
                    3'b011: data = {31'b0, a < b};
                    3'b100: data = a ^ b;
                    3'b101: data = a >> b[4:0];
                    3'b110: data = a | b;
                    default: data = a & b;
                endcase
            end else if (f7 == 7'h20 && inst[14:12] == 3'b000) data = a - b;
            else if (f7 == 7'h20 && inst[14:12] == 3'b101) data = $signed(a) >>> b[4:0];
            else legal = 1'b0;
        end else begin
            legal = 1'b0;
        end
        if (legal && rd != 5'd0) model_regs[rd] = data;  // x0 stays zero.
        return legal;
    endfunction

    task automatic send(input logic [31:0] inst, input string name);
        logic legal;
        logic [4:0] rd;
        logic [31:0] data;
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_inst = inst;
        legal = model_exec(inst, rd, data);
        name_q.push_back(name);
        ill_q.push_back(!legal);
        rd_q.push_back(rd);
        data_q.push_back(data);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            in_inst = 32'hffff_ffff;  // garbage must be ignored without the strobe.
        end
    endtask

    always @(posedge clk) begin
        if (!rstn) strobe_hist <= 2'b00;
        else strobe_hist <= {strobe_hist[0], in_valid};
    end

    // outputs are registered, so they are stable at the falling edge.
    always @(negedge clk) begin
        if (rstn) begin
            pulse = wb_valid || illegal;
            if (pulse != strobe_hist[1]) begin
                $display("a writeback or illegal pulse did not come one clock after its strobe");
                stop_on_error();
            end
            if (pulse) begin
                cur_name = name_q.pop_front();
                check_value({cur_name, " illegal"}, {31'b0, ill_q.pop_front()},
                            {31'b0, illegal});
                check_value({cur_name, " one pulse"}, 32'd0, {31'b0, wb_valid & illegal});
                if (wb_valid) begin
                    check_value({cur_name, " rd"}, {27'b0, rd_q.pop_front()}, {27'b0, wb_rd});
                    check_value({cur_name, " data"}, data_q.pop_front(), wb_data);
                end else begin
                    void'(rd_q.pop_front());
                    void'(data_q.pop_front());
                end
            end
        end
    end

    initial begin
        rstn = 1'b0;
        in_valid = 1'b0;
        in_inst = 32'h0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        model_regs[2] = 32'd1 << `LEN_MEMDATA_ADDR;
        model_regs[3] = `HEAP_POINTER_INIT;
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;

        send(make_i(12'd0, 5'd2, 3'b000, 5'd5), "reset x2");
        send(make_i(12'd0, 5'd3, 3'b000, 5'd6), "reset x3");
        send(make_i(12'd0, 5'd1, 3'b000, 5'd7), "reset x1");
        idle(2);

        send(make_u(20'hfffff, 5'd8), "lui negative");
        send(make_i(12'h123, 5'd8, 3'b000, 5'd8), "addi negative");
        send(make_i(12'd35, 5'd0, 3'b000, 5'd10), "addi shift amount");
        send(make_r(7'h20, 5'd10, 5'd8, 3'b101, 5'd9), "sra negative");
        send(make_r(7'h00, 5'd10, 5'd8, 3'b101, 5'd11), "srl negative");
        send(make_r(7'h00, 5'd10, 5'd8, 3'b001, 5'd12), "sll low bits");
        send(make_r(7'h00, 5'd10, 5'd8, 3'b010, 5'd13), "slt signed");
        send(make_r(7'h00, 5'd10, 5'd8, 3'b011, 5'd14), "sltu unsigned");
        send(make_i(12'h404, 5'd8, 3'b101, 5'd15), "srai negative");
        send(make_i(12'hfff, 5'd8, 3'b011, 5'd16), "sltiu all ones");
        send(make_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd18), "sub");
        idle(1);

        // each one reads the rd of the one before in the next cycle.
        send(make_i(12'd7, 5'd0, 3'b000, 5'd20), "chain start");
        repeat (4) send(make_r(7'h00, 5'd20, 5'd20, 3'b000, 5'd20), "chain add");
        send(make_r(7'h00, 5'd20, 5'd20, 3'b001, 5'd21), "chain sll");
        send(make_i(12'd5, 5'd0, 3'b000, 5'd23), "regfile path setup");
        send(make_i(12'd9, 5'd0, 3'b000, 5'd24), "regfile path gap");
        send(make_r(7'h00, 5'd24, 5'd23, 3'b000, 5'd25), "regfile and forward");

        send(make_i(12'd123, 5'd0, 3'b000, 5'd0), "write x0");
        send(make_i(12'd0, 5'd0, 3'b000, 5'd27), "read x0 after write");
        send(make_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd28), "read x0 regfile");

        send(make_u(20'habcde, 5'd21), "lui");
        send({12'h0, 5'd1, 3'b010, 5'd21, 7'b0000011}, "load opcode illegal");
        send(make_r(7'h01, 5'd2, 5'd3, 3'b000, 5'd21), "op funct7 illegal");
        send(make_i(12'h401, 5'd2, 3'b001, 5'd21), "slli funct7 illegal");
        send(make_i(12'd0, 5'd21, 3'b000, 5'd22), "lui value kept");
        idle(3);

        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            c = $random(seed);
            f3 = r[14:12];
            imm = r[31:20];
            if (f3 == 3'b001) imm[11:5] = 7'h00;
            if (f3 == 3'b101) imm[11:5] = r[31] ? 7'h20 : 7'h00;
            case (c[2:0])
                3'd0, 3'd1, 3'd2: send(make_r(((f3 == 3'b000 || f3 == 3'b101) && r[31]) ?
                                       7'h20 : 7'h00, r[24:20], r[19:15], f3, r[11:7]),
                                       "random op");
                3'd3, 3'd4, 3'd5: send(make_i(imm, r[19:15], f3, r[11:7]), "random op-imm");
                3'd6: send(make_u(r[31:12], r[11:7]), "random lui");
                default: send(r, "random word");
            endcase
            if (c[3] && c[4]) idle(1);
        end
        idle(1);

        wait_count = 0;
        while (name_q.size() != 0 && wait_count < 20) begin
            @(posedge clk);
            wait_count++;
        end
        if (name_q.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("the output for %0d instructions never arrived", name_q.size());
            stop_on_error();
        end
    end

endmodule

//--- build.f
+incdir+logic
logic/core_pkg.sv
logic/issue_if.sv
logic/reg_file.sv
logic/inst_decode.sv
logic/issue_stage.sv
logic/alu_stage.sv
logic/exec_core.sv
sim/exec_core_tb.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module exec_core

sim:
	verilator --binary --timing --assert -f build.f --top-module exec_core_tb -o exec_core_sim
	./obj_dir/exec_core_sim | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir
